// File: Makefile
# Verilator build and run of the processor test harness

SIM := obj_dir/processorci_sim

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		-f all.f --top-module processorci_tb -o processorci_sim

run: build
	./$(SIM) | tee sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ns \
		-f all.f --top-module processorci_tb

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+common
common/core_pkg.sv
hw/core/core_regfile.sv
hw/core/core_alu.sv
hw/core/core_ctrl.sv
hw/core/tiny_core.sv
hw/wb_master.sv
hw/processorci_top.sv
dv/processorci_assertions.sv
dv/processorci_tb.sv

// File: common/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// First fetch address once reset is released
`define CORE_RESET_PC 32'h0000_0000

// Register file depth, r0 included
`define CORE_NUM_REGS 8

// Wishbone address and data width, also the core's datapath width
`define CORE_BUS_W 32

`endif

// File: common/core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,  // Register-register operation
        OP_ADDI = 4'h1,
        OP_LW   = 4'h2,
        OP_SW   = 4'h3,
        OP_BEQ  = 4'h4   // Compares rd with rs1
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6
    } alu_op_e;

    // Register format
    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [15:0] rsvd;
        alu_op_e     funct;
    } r_fmt_t;

    // Immediate format used by ADDI, LW, SW and BEQ
    typedef struct packed {
        opcode_e            opcode;
        logic [2:0]         rd;
        logic [2:0]         rs1;
        logic [5:0]         rsvd;
        logic signed [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef struct packed {
        logic                   valid;  // Held until done
        logic                   we;
        logic [`CORE_BUS_W-1:0] addr;
        logic [`CORE_BUS_W-1:0] wdata;
    } wb_req_t;

    typedef struct packed {
        logic                   done;   // Single cycle
        logic [`CORE_BUS_W-1:0] rdata;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: dv/processorci_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module processorci_assertions (
    input logic                   sys_clk,
    input logic                   reset_i,
    input logic                   cyc_i,
    input logic                   stb_i,
    input logic                   we_i,
    input logic [`CORE_BUS_W-1:0] addr_i,
    input logic [`CORE_BUS_W-1:0] wdata_i,
    input logic                   ack_i
);

    // Strobe only inside a bus cycle
    stb_within_cyc: assert property (@(posedge sys_clk) disable iff (reset_i)
        stb_i |-> cyc_i)
        else $error("stb high while cyc low");

    addr_word_aligned: assert property (@(posedge sys_clk) disable iff (reset_i)
        stb_i |-> (addr_i[1:0] == 2'b00))
        else $error("bus address not word aligned");

    // Request held through wait states
    req_held_until_ack: assert property (@(posedge sys_clk) disable iff (reset_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(addr_i) && $stable(we_i) && $stable(wdata_i)))
        else $error("bus request changed before ack");

    cyc_low_after_reset: assert property (@(posedge sys_clk)
        reset_i |=> !cyc_i)
        else $error("cyc high in the cycle after reset");

endmodule

`default_nettype wire

// File: dv/processorci_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module processorci_tb;
    import core_pkg::*;

    localparam int           W           = `CORE_BUS_W;
    localparam int           PROG_LEN    = 200;
    localparam int           WATCHDOG_NS = PROG_LEN * 3 * 8 * 4 + 1000;  // Margin for reset
    localparam logic [W-1:0] END_PC      = `CORE_RESET_PC + 32'(PROG_LEN * 4);

    logic         sys_clk = 1'b0;
    logic         reset_i;
    logic         core_cyc_o;
    logic         core_stb_o;
    logic         core_we_o;
    logic [W-1:0] core_addr_o;
    logic [W-1:0] core_data_out_o;
    logic [W-1:0] core_data_in_i;
    logic         core_ack_i;

    logic [W-1:0] imem [256];
    logic [W-1:0] dmem [64];    // Bus side words at 0x1000
    logic [W-1:0] m_dmem [64];  // Model copy
    logic [W-1:0] m_regs [8];
    logic [W-1:0] m_pc;
    logic [31:0]  lfsr = 32'hc02503f7;
    int           errors = 0;

    always #2 sys_clk = ~sys_clk;

    processorci_top processorci_top_inst (.*);

    bind processorci_top processorci_assertions assertions_inst (
        .sys_clk (sys_clk),
        .reset_i (reset_i),
        .cyc_i   (core_cyc_o),
        .stb_i   (core_stb_o),
        .we_i    (core_we_o),
        .addr_i  (core_addr_o),
        .wdata_i (core_data_out_o),
        .ack_i   (core_ack_i)
    );

    // Galois LFSR stepped once per bit drawn
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [W-1:0] fill_word(input logic [W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [W-1:0] bus_read(input logic [W-1:0] a);
        if (a[31:8] == 24'h000010) begin
            return dmem[a[7:2]];
        end
        return (a < 32'h400) ? imem[a[9:2]] : fill_word(a);
    endfunction

    function automatic logic [W-1:0] encode_i(input opcode_e op, input logic [2:0] rd,
                                              input logic [2:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, 6'h00, imm};
    endfunction

    // Reference ALU shifting by the low five bits
    function automatic logic [W-1:0] model_alu(input logic [2:0] funct,
                                               input logic [W-1:0] a, input logic [W-1:0] b);
        case (funct)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic log_mismatch(input string what, input logic [W-1:0] got,
                                input logic [W-1:0] exp);
        $display("mismatch %s: got %h expected %h at %0t", what, got, exp, $time);
        errors++;
    endtask

    task automatic build_program();
        int         i;
        int         room;
        int         off;
        logic [2:0] kind;
        logic [2:0] rd;
        logic [2:0] rs1;
        for (int a = 0; a < 256; a++) begin
            imem[a] = fill_word(32'(a) << 2);
        end
        for (int a = 0; a < 64; a++) begin
            dmem[a]   = fill_word(32'h1000 + (32'(a) << 2));
            m_dmem[a] = dmem[a];
        end
        i = 0;
        while (i < PROG_LEN) begin
            kind = 3'(rand_bits(3));
            rd   = 3'(rand_bits(3));
            rs1  = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: imem[i] = {OP_ALU, rd, rs1, 3'(rand_bits(3)), 16'h0000,
                                       3'(rand_bits(3) % 7)};
                3'd2, 3'd7: imem[i] = encode_i(OP_ADDI, rd, rs1, 16'(rand_bits(16)));
                3'd3: imem[i] = encode_i(OP_LW, rd, 3'd0, {8'h10, 6'(rand_bits(6)), 2'b00});
                3'd4: imem[i] = encode_i(OP_SW, rd, 3'd0, {8'h10, 6'(rand_bits(6)), 2'b00});
                3'd5: begin  // Load then store of the same register
                    imem[i] = encode_i(OP_LW, rd, 3'd0, {8'h10, 6'(rand_bits(6)), 2'b00});
                    if (i + 1 < PROG_LEN) begin
                        i++;
                        imem[i] = encode_i(OP_SW, rd, 3'd0, {8'h10, 6'(rand_bits(6)), 2'b00});
                    end
                end
                default: begin
                    room = PROG_LEN - 1 - i;  // Never past the final branch
                    off  = int'(rand_bits(2));
                    if (off > room) begin
                        off = room;
                    end
                    imem[i] = encode_i(OP_BEQ, rd, rs1, 16'(off));
                end
            endcase
            i++;
        end
        imem[PROG_LEN] = encode_i(OP_BEQ, 3'd0, 3'd0, 16'hffff);  // Branch to self
    endtask

    // One Wishbone cycle with 0 to 3 wait states
    task automatic serve_cycle(output logic [W-1:0] addr, output logic we,
                               output logic [W-1:0] wdata);
        int waits;
        while (core_stb_o !== 1'b1) begin
            @(negedge sys_clk);
        end
        if (core_cyc_o !== 1'b1) begin
            $display("cyc low while stb high at %0t", $time);
            errors++;
        end
        addr  = core_addr_o;
        we    = core_we_o;
        wdata = core_data_out_o;
        waits = int'(rand_bits(2));
        while (waits > 0) begin
            @(negedge sys_clk);
            if ((core_stb_o !== 1'b1) || (core_cyc_o !== 1'b1)) begin
                $display("cyc or stb fell before the cycle was acknowledged at %0t", $time);
                errors++;
            end
            if (core_addr_o !== addr) begin
                log_mismatch("core_addr_o held", core_addr_o, addr);
            end
            if (core_we_o !== we) begin
                log_mismatch("core_we_o held", W'(core_we_o), W'(we));
            end
            if (core_data_out_o !== wdata) begin
                log_mismatch("core_data_out_o held", core_data_out_o, wdata);
            end
            waits--;
        end
        core_data_in_i = bus_read(addr);
        core_ack_i     = 1'b1;
        @(negedge sys_clk);
        if ((core_cyc_o !== 1'b0) || (core_stb_o !== 1'b0)) begin
            $display("cyc or stb still high in the cycle after ack at %0t", $time);
            errors++;
        end
        if (we && (addr[31:8] == 24'h000010)) begin
            dmem[addr[7:2]] = wdata;
        end
        core_ack_i     = 1'b0;
        core_data_in_i = ~core_data_in_i;  // Read data only valid with ack
    endtask

    initial begin
        logic [W-1:0] addr;
        logic         we;
        logic [W-1:0] wdata;
        logic [W-1:0] instr;
        logic [W-1:0] imm;
        logic [W-1:0] ea;
        logic [W-1:0] next_pc;
        logic [2:0]   rd;
        logic [2:0]   rs1;
        int           self_fetches;
        reset_i        = 1'b1;
        core_ack_i     = 1'b0;
        core_data_in_i = '0;
        build_program();
        for (int k = 0; k < 8; k++) begin
            m_regs[k] = '0;
        end
        m_pc         = `CORE_RESET_PC;
        self_fetches = 0;
        repeat (10) @(posedge sys_clk);
        @(negedge sys_clk);
        reset_i = 1'b0;

        while ((self_fetches < 4) && (errors <= 20)) begin
            serve_cycle(addr, we, wdata);
            if (addr !== m_pc) begin
                log_mismatch("fetch core_addr_o", addr, m_pc);
            end
            if (we !== 1'b0) begin
                log_mismatch("fetch core_we_o", W'(we), W'(1'b0));
            end
            if (m_pc == END_PC) begin
                self_fetches++;
            end
            instr   = imem[m_pc[9:2]];
            rd      = instr[27:25];
            rs1     = instr[24:22];
            imm     = {{16{instr[15]}}, instr[15:0]};
            ea      = m_regs[rs1] + imm;
            next_pc = m_pc + 32'd4;
            case (instr[31:28])
                OP_ALU:  m_regs[rd] = model_alu(instr[2:0], m_regs[rs1], m_regs[instr[21:19]]);
                OP_ADDI: m_regs[rd] = ea;
                OP_LW: begin
                    serve_cycle(addr, we, wdata);
                    if (addr !== ea) begin
                        log_mismatch("load core_addr_o", addr, ea);
                    end
                    if (we !== 1'b0) begin
                        log_mismatch("load core_we_o", W'(we), W'(1'b0));
                    end
                    m_regs[rd] = m_dmem[ea[7:2]];
                end
                OP_SW: begin
                    serve_cycle(addr, we, wdata);
                    if (addr !== ea) begin
                        log_mismatch("store core_addr_o", addr, ea);
                    end
                    if (we !== 1'b1) begin
                        log_mismatch("store core_we_o", W'(we), W'(1'b1));
                    end
                    if (wdata !== m_regs[rd]) begin
                        log_mismatch("store core_data_out_o", wdata, m_regs[rd]);
                    end
                    m_dmem[ea[7:2]] = m_regs[rd];
                end
                OP_BEQ: begin
                    if (m_regs[rd] == m_regs[rs1]) begin
                        next_pc = m_pc + 32'd4 + (imm << 2);
                    end
                end
                default: ;  // No operation
            endcase
            m_regs[0] = '0;
            m_pc      = next_pc;
        end

        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the final branch was fetched four times");
        $display("run aborted, %0d errors", errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/core/core_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module core_alu (
    input  core_pkg::alu_op_e      op_i,
    input  logic [`CORE_BUS_W-1:0] a_i,
    input  logic [`CORE_BUS_W-1:0] b_i,
    output logic [`CORE_BUS_W-1:0] result_o
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // Shift amount from low bits only

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;  // Also ADDI and address generation
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLL: result_o = a_i << shamt;
            ALU_SRL: result_o = a_i >> shamt;  // Logical shift with zero fill
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/core/core_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module core_ctrl (
    input  logic                   sys_clk,
    input  logic                   reset_i,
    input  core_pkg::wb_rsp_t      rsp_i,
    input  logic [`CORE_BUS_W-1:0] rs1_data_i,
    input  logic [`CORE_BUS_W-1:0] rs2_data_i,
    input  logic [`CORE_BUS_W-1:0] alu_result_i,
    output core_pkg::wb_req_t      req_o,
    output logic [2:0]             rs1_o,
    output logic [2:0]             rs2_o,
    output logic [2:0]             rd_o,
    output logic                   wr_en_o,
    output logic [`CORE_BUS_W-1:0] wr_data_o,
    output core_pkg::alu_op_e      alu_op_o,
    output logic [`CORE_BUS_W-1:0] alu_b_o
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2
    } state_e;

    state_e                 state_q;
    logic [`CORE_BUS_W-1:0] pc_q;
    logic                   bubble_q;  // Keeps valid low for a cycle after each reply
    instr_t                 instr_q;
    opcode_e                opcode;
    logic [`CORE_BUS_W-1:0] imm_ext;
    logic                   is_mem_op;
    logic                   take_branch;

    // Opcode sits in the same bits for both views
    assign opcode    = instr_q.r.opcode;
    assign imm_ext   = {{(`CORE_BUS_W-16){instr_q.i.imm[15]}}, instr_q.i.imm};
    assign is_mem_op = (opcode == OP_LW) || (opcode == OP_SW);

    // Second read port fetches rd for store data and the BEQ compare
    assign rs1_o = instr_q.r.rs1;
    assign rs2_o = (opcode == OP_ALU) ? instr_q.r.rs2 : instr_q.i.rd;
    assign rd_o  = instr_q.r.rd;

    assign alu_op_o = (opcode == OP_ALU) ? instr_q.r.funct : ALU_ADD;
    assign alu_b_o  = (opcode == OP_ALU) ? rs2_data_i : imm_ext;

    assign take_branch = (opcode == OP_BEQ) && (rs2_data_i == rs1_data_i);

    // Writeback selection
    always_comb begin
        wr_en_o   = 1'b0;
        wr_data_o = alu_result_i;
        if ((state_q == EXEC) && ((opcode == OP_ALU) || (opcode == OP_ADDI))) begin
            wr_en_o = 1'b1;
        end else if ((state_q == MEM) && (opcode == OP_LW) && rsp_i.done) begin
            wr_en_o   = 1'b1;
            wr_data_o = rsp_i.rdata;  // Sampled in the ack cycle
        end
    end

    // Bus request fields stay put while the state holds
    always_comb begin
        req_o.valid = ((state_q == FETCH) || (state_q == MEM)) && !bubble_q;
        req_o.we    = (state_q == MEM) && (opcode == OP_SW);
        req_o.addr  = (state_q == FETCH) ? pc_q : alu_result_i;
        req_o.wdata = rs2_data_i;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state_q  <= FETCH;
            pc_q     <= `CORE_RESET_PC;
            bubble_q <= 1'b1;
        end else begin
            bubble_q <= rsp_i.done;
            case (state_q)
                FETCH: begin
                    if (rsp_i.done) begin
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    if (is_mem_op) begin
                        state_q <= MEM;
                    end else begin
                        state_q <= FETCH;
                        pc_q    <= take_branch ? (pc_q + 32'd4 + (imm_ext << 2))
                                               : (pc_q + 32'd4);
                    end
                end
                MEM: begin
                    if (rsp_i.done) begin
                        state_q <= FETCH;
                        pc_q    <= pc_q + 32'd4;
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge sys_clk) begin
        if ((state_q == FETCH) && rsp_i.done) begin
            instr_q <= instr_t'(rsp_i.rdata);
        end
    end

endmodule

`default_nettype wire

// File: hw/core/core_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module core_regfile (
    input  logic                   sys_clk,
    input  logic                   reset_i,
    input  logic [2:0]             rs1_i,
    input  logic [2:0]             rs2_i,
    input  logic [2:0]             rd_i,
    input  logic                   wr_en_i,
    input  logic [`CORE_BUS_W-1:0] wr_data_i,
    output logic [`CORE_BUS_W-1:0] rs1_data_o,
    output logic [`CORE_BUS_W-1:0] rs2_data_o
);

    logic [`CORE_BUS_W-1:0] regs_q [`CORE_NUM_REGS];

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != 3'd0)) begin  // r0 never written
            regs_q[rd_i] <= wr_data_i;
        end
    end

    // Asynchronous reads
    assign rs1_data_o = regs_q[rs1_i];
    assign rs2_data_o = regs_q[rs2_i];

endmodule

`default_nettype wire

// File: hw/core/tiny_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module tiny_core (
    input  logic              sys_clk,
    input  logic              reset_i,
    input  core_pkg::wb_rsp_t rsp_i,
    output core_pkg::wb_req_t req_o
);
    import core_pkg::*;

    logic [2:0]             rs1;
    logic [2:0]             rs2;
    logic [2:0]             rd;
    logic                   wr_en;
    logic [`CORE_BUS_W-1:0] wr_data;
    logic [`CORE_BUS_W-1:0] rs1_data;
    logic [`CORE_BUS_W-1:0] rs2_data;
    logic [`CORE_BUS_W-1:0] alu_b;      // Register or immediate chosen by the controller
    logic [`CORE_BUS_W-1:0] alu_result;
    alu_op_e                alu_op;

    core_ctrl u_ctrl (
        .sys_clk      (sys_clk),
        .reset_i      (reset_i),
        .rsp_i        (rsp_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_result_i (alu_result),
        .req_o        (req_o),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd_o         (rd),
        .wr_en_o      (wr_en),
        .wr_data_o    (wr_data),
        .alu_op_o     (alu_op),
        .alu_b_o      (alu_b)
    );

    core_regfile u_regfile (
        .sys_clk    (sys_clk),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // First operand is always rs1
    core_alu u_alu (
        .op_i     (alu_op),
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

endmodule

`default_nettype wire

// File: hw/processorci_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module processorci_top (
    input  logic                   sys_clk,          // System clock
    input  logic                   reset_i,

    output logic                   core_cyc_o,       // Bus cycle active
    output logic                   core_stb_o,
    output logic                   core_we_o,        // High for a write
    output logic [`CORE_BUS_W-1:0] core_addr_o,
    output logic [`CORE_BUS_W-1:0] core_data_out_o,  // Write data
    input  logic [`CORE_BUS_W-1:0] core_data_in_i,   // Read data
    input  logic                   core_ack_i
);
    import core_pkg::*;

    wb_req_t core_req;
    wb_rsp_t core_rsp;

    tiny_core u_core (
        .sys_clk (sys_clk),
        .reset_i (reset_i),
        .rsp_i   (core_rsp),
        .req_o   (core_req)
    );

    wb_master u_wb_master (
        .sys_clk         (sys_clk),
        .reset_i         (reset_i),
        .req_i           (core_req),
        .rsp_o           (core_rsp),
        .core_cyc_o      (core_cyc_o),
        .core_stb_o      (core_stb_o),
        .core_we_o       (core_we_o),
        .core_addr_o     (core_addr_o),
        .core_data_out_o (core_data_out_o),
        .core_data_in_i  (core_data_in_i),
        .core_ack_i      (core_ack_i)
    );

endmodule

`default_nettype wire

// File: hw/wb_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module wb_master (
    input  logic                   sys_clk,
    input  logic                   reset_i,
    input  core_pkg::wb_req_t      req_i,
    output core_pkg::wb_rsp_t      rsp_o,
    output logic                   core_cyc_o,
    output logic                   core_stb_o,
    output logic                   core_we_o,
    output logic [`CORE_BUS_W-1:0] core_addr_o,
    output logic [`CORE_BUS_W-1:0] core_data_out_o,
    input  logic [`CORE_BUS_W-1:0] core_data_in_i,
    input  logic                   core_ack_i
);

    logic                   busy_q;   // Cycle in progress
    logic                   we_q;
    logic [`CORE_BUS_W-1:0] addr_q;
    logic [`CORE_BUS_W-1:0] wdata_q;
    logic                   accept;

    // Only an idle master takes a new request
    assign accept = !busy_q && req_i.valid;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
            we_q   <= req_i.we;
        end else if (busy_q && core_ack_i) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
        end
    end

    assign core_cyc_o      = busy_q;
    assign core_stb_o      = busy_q;  // Single transfer per cycle
    assign core_we_o       = we_q;
    assign core_addr_o     = addr_q;
    assign core_data_out_o = wdata_q;

    // Reply in the ack cycle itself
    assign rsp_o.done  = busy_q && core_ack_i;
    assign rsp_o.rdata = core_data_in_i;

endmodule

`default_nettype wire
